// File: user_io.f
user_io_types_pkg.sv
user_io_cmd_pkg.sv
wb_if.sv
spi_slave.sv
byte_sync.sv
cmd_decoder.sv
io_regs.sv
user_io.sv
user_io_assertions.sv
tb_user_io.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exits non-zero on failure.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_user_io -f user_io.f -o sim_user_io
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_user_io > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0

// File: tb_user_io.sv
// Testbench for user_io. Random transfers from a fixed seed are checked
// against a model of the outputs and the MISO bytes.
// Output registers are only compared after their first write.
// Keyboard transfers send one to three codes, each with optional prefixes.
`timescale 1ns/1ns
`default_nettype none

module tb_user_io
	import user_io_types_pkg::*, user_io_cmd_pkg::*;
();
	localparam int N_XFER      = 60;
	localparam int MAX_BYTES   = 10;
	// 8 bits of 8 clk_sys cycles, plus the chip select gaps
	localparam int XFER_CYCLES = MAX_BYTES * 64 + 20;

	logic clk_sys;
	logic SPI_SS_IO;
	logic SPI_CLK_i;
	logic SPI_MOSI_i;
	logic SPI_MISO_o;
	byte_t leds_i;
	logic [1:0] buttons_o;
	logic [1:0] switches_o;
	logic scandoubler_disable_o;
	logic ypbpr_o;
	logic no_csync_o;
	joystick_t joystick_0_o;
	joystick_t joystick_1_o;
	status_t status_o;
	byte_t key_code_o;
	logic key_pressed_o;
	logic key_extended_o;
	logic key_strobe_o;

	integer seed = 32'hedae_8455;
	byte_t tx_q[$];
	byte_t rx_q[$];
	// key events packed as {code, pressed, extended}
	logic [9:0] exp_keys[$];
	logic [9:0] got_keys[$];

	user_io uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (key_strobe_o === 1'b1)
			got_keys.push_back({key_code_o, key_pressed_o, key_extended_o});
	end

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at first error");
	endtask

	initial begin
		repeat (N_XFER * XFER_CYCLES * 2 + 16) @(posedge clk_sys);
		$display("timeout: transfers did not finish in time");
		stop_run();
	end

	function automatic byte_t rand_byte();
		return byte_t'($random(seed));
	endfunction

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_joystick(input string name, input joystick_t exp,
			input joystick_t act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_status(input string name, input status_t exp, input status_t act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_key(input string name, input logic [9:0] exp, input logic [9:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %h pressed %b ext %b, actual %h pressed %b ext %b",
				name, exp[9:2], exp[1], exp[0], act[9:2], act[1], act[0]);
			stop_run();
		end
	endtask

	// one byte, 4 cycles low and 4 high per bit; MISO is read at the rising edge
	task automatic send_byte(input byte_t tx, output byte_t rx);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk_sys);
			SPI_MOSI_i <= tx[i];
			SPI_CLK_i  <= 1'b0;
			repeat (4) @(posedge clk_sys);
			rx[i] = SPI_MISO_o;
			SPI_CLK_i <= 1'b1;
			repeat (3) @(posedge clk_sys);
		end
	endtask

	task automatic run_transfer();
		byte_t rx_b;
		rx_q.delete();
		@(posedge clk_sys);
		SPI_SS_IO <= 1'b0;
		foreach (tx_q[k]) begin
			send_byte(tx_q[k], rx_b);
			rx_q.push_back(rx_b);
		end
		@(posedge clk_sys);
		SPI_CLK_i <= 1'b0;
		repeat (4) @(posedge clk_sys);
		SPI_SS_IO <= 1'b1;
		repeat (8) @(posedge clk_sys);
	endtask

	initial begin
		int kind;
		int nb;
		byte_t b;
		byte_t exp_but_sw;
		byte_t exp_leds;
		joystick_t exp_joy[2];
		status_t exp_status;
		logic but_ok;
		logic [1:0] joy_ok;
		logic status_ok;
		logic pressed;
		logic ext;

		SPI_SS_IO  <= 1'b1;
		SPI_CLK_i  <= 1'b0;
		SPI_MOSI_i <= 1'b0;
		leds_i     <= '0;
		exp_leds   = '0;
		but_ok     = 1'b0;
		joy_ok     = '0;
		status_ok  = 1'b0;
		repeat (16) @(posedge clk_sys);

		for (int n = 0; n < N_XFER; n++) begin
			// every kind once, then random
			kind = (n < 6) ? n : int'($unsigned($random(seed)) % 6);
			tx_q.delete();
			case (kind)
				0: begin
					b = rand_byte();
					tx_q = {CMD_BUT_SW, b};
					exp_but_sw = b;
					but_ok = 1'b1;
				end
				1, 2: begin
					tx_q.push_back((kind == 1) ? CMD_JOY0 : CMD_JOY1);
					nb = JOY_BYTES + int'($unsigned($random(seed)) % 3);
					for (int i = 0; i < nb; i++) begin
						b = rand_byte();
						tx_q.push_back(b);
						if (i < JOY_BYTES)
							exp_joy[kind - 1][8 * i +: 8] = b;
					end
					joy_ok[kind - 1] = 1'b1;
				end
				3: begin
					tx_q.push_back(CMD_STATUS);
					for (int i = 0; i < STATUS_BYTES; i++) begin
						b = rand_byte();
						tx_q.push_back(b);
						exp_status[8 * i +: 8] = b;
					end
					status_ok = 1'b1;
				end
				4: begin
					tx_q.push_back(CMD_KBD);
					pressed = 1'b1;
					ext = 1'b0;
					nb = 1 + int'($unsigned($random(seed)) % 3);
					// the event starts once per transfer, prefixes stick
					for (int i = 0; i < nb; i++) begin
						if ($random(seed) & 1) begin
							tx_q.push_back(KBD_EXT);
							ext = 1'b1;
						end
						if ($random(seed) & 1) begin
							tx_q.push_back(KBD_BREAK);
							pressed = 1'b0;
						end
						do
							b = rand_byte();
						while (b == KBD_EXT || b == KBD_BREAK);
						tx_q.push_back(b);
						exp_keys.push_back({b, pressed, ext});
					end
				end
				default: begin
					exp_leds = rand_byte();
					leds_i <= exp_leds;
					tx_q.push_back(CMD_LEDS);
					nb = 1 + int'($unsigned($random(seed)) % 3);
					for (int i = 0; i < nb; i++)
						tx_q.push_back(rand_byte());
				end
			endcase

			run_transfer();

			check_byte("miso core type", CORE_TYPE, rx_q[0]);
			for (int k = 1; k < rx_q.size(); k++)
				check_byte("miso response",
					(tx_q[0] == CMD_LEDS) ? exp_leds : 8'h00, rx_q[k]);
			if (but_ok)
				check_byte("buttons/switches", {1'b0, exp_but_sw[6:0]},
					{1'b0, no_csync_o, ypbpr_o, scandoubler_disable_o, switches_o, buttons_o});
			if (joy_ok[0])
				check_joystick("joystick_0", exp_joy[0], joystick_0_o);
			if (joy_ok[1])
				check_joystick("joystick_1", exp_joy[1], joystick_1_o);
			if (status_ok)
				check_status("status", exp_status, status_o);
			if (got_keys.size() != exp_keys.size()) begin
				$display("wrong number of key strobes: expected %0d, got %0d",
					exp_keys.size(), got_keys.size());
				stop_run();
			end
			foreach (exp_keys[k])
				check_key("key event", exp_keys[k], got_keys[k]);
			exp_keys.delete();
			got_keys.delete();
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: user_io_assertions.sv
// Protocol checks bound into cmd_decoder: Wishbone handshake,
// key strobe width and byte spacing. Disabled while SPI_SS_IO is high.
`timescale 1ns/1ns
`default_nettype none

module user_io_assertions (
	input logic clk_sys,
	input logic SPI_SS_IO,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic new_byte_i,
	input logic key_strobe_i
);
	ack_in_stb: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		ack_i |-> stb_i)
		else $error("ack seen without stb");

	// master keeps the request up until the slave answers
	stb_until_ack: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		stb_i && !ack_i |=> stb_i)
		else $error("stb dropped before ack");

	strobe_one_cycle: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		key_strobe_i |=> !key_strobe_i)
		else $error("key_strobe longer than one cycle");

	byte_while_idle: assert property (@(posedge clk_sys) disable iff (SPI_SS_IO)
		new_byte_i |-> !cyc_i)
		else $error("byte arrived during a pending bus write");

endmodule

bind cmd_decoder user_io_assertions u_assert (
	.clk_sys      (clk_sys),
	.SPI_SS_IO    (SPI_SS_IO),
	.cyc_i        (bus.cyc),
	.stb_i        (bus.stb),
	.ack_i        (bus.ack),
	.new_byte_i   (new_byte_i),
	.key_strobe_i (key_strobe_o)
);

`default_nettype wire

// File: user_io.sv
// User I/O block: SPI slave to the I/O controller, command
// decoder and output registers. SPI_CLK at most clk_sys/4; SS must
// stay low 4 clk_sys cycles after the last SPI_CLK rising edge.
// Outputs settle a few cycles after the last byte, so sample them
// after SPI_SS_IO has risen.
`timescale 1ns/1ns
`default_nettype none

module user_io
	import user_io_types_pkg::*;
(
	input  logic      clk_sys,
	input  logic      SPI_SS_IO,
	input  logic      SPI_CLK_i,
	input  logic      SPI_MOSI_i,
	output logic      SPI_MISO_o,
	input  byte_t     leds_i,
	output logic [1:0] buttons_o,
	output logic [1:0] switches_o,
	output logic      scandoubler_disable_o,
	output logic      ypbpr_o,
	output logic      no_csync_o,
	output joystick_t joystick_0_o,
	output joystick_t joystick_1_o,
	output status_t   status_o,
	output byte_t     key_code_o,
	output logic      key_pressed_o,
	output logic      key_extended_o,
	output logic      key_strobe_o
);
	byte_t   rx_byte;
	logic    rx_toggle;
	logic    rx_first;
	byte_t   sys_byte;
	logic    sys_new;
	logic    sys_first;
	but_sw_t but_sw;

	wb_if reg_bus ();

	spi_slave u_spi (
		.clk_spi_i   (SPI_CLK_i),
		.SPI_SS_IO   (SPI_SS_IO),
		.mosi_i      (SPI_MOSI_i),
		.miso_o      (SPI_MISO_o),
		.leds_i      (leds_i),
		.rx_byte_o   (rx_byte),
		.rx_toggle_o (rx_toggle),
		.rx_first_o  (rx_first)
	);

	byte_sync u_sync (
		.clk_sys     (clk_sys),
		.SPI_SS_IO   (SPI_SS_IO),
		.rx_byte_i   (rx_byte),
		.rx_toggle_i (rx_toggle),
		.rx_first_i  (rx_first),
		.byte_o      (sys_byte),
		.new_byte_o  (sys_new),
		.first_o     (sys_first)
	);

	cmd_decoder u_dec (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.byte_i         (sys_byte),
		.new_byte_i     (sys_new),
		.first_i        (sys_first),
		.bus            (reg_bus.master),
		.key_code_o     (key_code_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o),
		.key_strobe_o   (key_strobe_o)
	);

	io_regs u_regs (
		.clk_sys      (clk_sys),
		.SPI_SS_IO    (SPI_SS_IO),
		.bus          (reg_bus.slave),
		.but_sw_o     (but_sw),
		.joystick_0_o (joystick_0_o),
		.joystick_1_o (joystick_1_o),
		.status_o     (status_o)
	);

	// bit 7 of the buttons/switches byte is unassigned
	assign buttons_o             = but_sw[1:0];
	assign switches_o            = but_sw[3:2];
	assign scandoubler_disable_o = but_sw[4];
	assign ypbpr_o               = but_sw[5];
	assign no_csync_o            = but_sw[6];

endmodule

`default_nettype wire

// File: io_regs.sv
// Output register block on the internal Wishbone bus.
// Registers hold no reset value and are undefined until written.
// Unused addresses are acknowledged and ignored.
`timescale 1ns/1ns
`default_nettype none

module io_regs
	import user_io_types_pkg::*, user_io_cmd_pkg::*;
(
	input  logic      clk_sys,
	input  logic      SPI_SS_IO,
	wb_if.slave       bus,
	output but_sw_t   but_sw_o,
	output joystick_t joystick_0_o,
	output joystick_t joystick_1_o,
	output status_t   status_o
);
	logic       wr_en;
	logic [1:0] joy_lane;
	logic [2:0] st_lane;

	// write on the edge that raises ack
	assign wr_en    = bus.cyc && bus.stb && bus.we && !bus.ack;
	assign joy_lane = bus.adr[1:0];
	assign st_lane  = bus.adr[2:0];

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			bus.ack <= 1'b0;
		else
			bus.ack <= bus.cyc && bus.stb && !bus.ack;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			if (bus.adr == ADR_BUT_SW)
				but_sw_o <= bus.dat_w;
			// joystick bases are 4-byte aligned, status 8-byte aligned
			if (bus.adr[4:2] == ADR_JOY0[4:2])
				joystick_0_o[{joy_lane, 3'b000} +: 8] <= bus.dat_w;
			if (bus.adr[4:2] == ADR_JOY1[4:2])
				joystick_1_o[{joy_lane, 3'b000} +: 8] <= bus.dat_w;
			if (bus.adr[4:3] == ADR_STATUS[4:3])
				status_o[{st_lane, 3'b000} +: 8] <= bus.dat_w;
		end
	end

endmodule

`default_nettype wire

// File: cmd_decoder.sv
// Command decoder in clk_sys. Turns each data byte of a known
// command into one register bus write, and decodes PS/2 codes.
// Bytes must arrive far enough apart for a write to finish;
// a byte arriving during a pending write is dropped.
`timescale 1ns/1ns
`default_nettype none

module cmd_decoder
	import user_io_types_pkg::*, user_io_cmd_pkg::*;
(
	input  logic  clk_sys,
	input  logic  SPI_SS_IO,
	input  byte_t byte_i,
	input  logic  new_byte_i,
	input  logic  first_i,
	wb_if.master  bus,
	output byte_t key_code_o,
	output logic  key_pressed_o,
	output logic  key_extended_o,
	output logic  key_strobe_o
);
	byte_t      cmd;
	// index of the data byte, 0 is the byte after the command
	logic [3:0] byte_idx;
	logic       data_byte;
	logic       wr_hit;
	wb_adr_t    wr_adr;
	logic       wr_start;
	logic       kbd_byte;
	logic       kbd_prefix;
	logic       ev_pressed;
	logic       ev_extended;
	logic       pressed_q;
	logic       extended_q;

	assign data_byte = new_byte_i && !first_i;

	always_comb begin
		wr_hit = 1'b0;
		wr_adr = ADR_BUT_SW;
		case (cmd)
			CMD_BUT_SW: wr_hit = (byte_idx == 4'd0);
			CMD_JOY0: begin
				wr_hit = (byte_idx < JOY_BYTES);
				wr_adr = ADR_JOY0 + wb_adr_t'(byte_idx[1:0]);
			end
			CMD_JOY1: begin
				wr_hit = (byte_idx < JOY_BYTES);
				wr_adr = ADR_JOY1 + wb_adr_t'(byte_idx[1:0]);
			end
			CMD_STATUS: begin
				wr_hit = (byte_idx < STATUS_BYTES);
				wr_adr = ADR_STATUS + wb_adr_t'(byte_idx[2:0]);
			end
			default: wr_hit = 1'b0;
		endcase
	end

	assign wr_start = data_byte && wr_hit && !bus.cyc;

	// keyboard event state restarts with the first data byte
	assign kbd_byte    = data_byte && (cmd == CMD_KBD);
	assign kbd_prefix  = (byte_i == KBD_EXT) || (byte_i == KBD_BREAK);
	assign ev_pressed  = (byte_idx == 4'd0) ? 1'b1 : pressed_q;
	assign ev_extended = (byte_idx == 4'd0) ? 1'b0 : extended_q;

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			cmd          <= '0;
			byte_idx     <= '0;
			bus.cyc      <= 1'b0;
			bus.stb      <= 1'b0;
			bus.we       <= 1'b0;
			key_strobe_o <= 1'b0;
		end else begin
			key_strobe_o <= kbd_byte && !kbd_prefix;
			if (new_byte_i && first_i) begin
				cmd      <= byte_i;
				byte_idx <= '0;
			end else if (data_byte && byte_idx != 4'hf) begin
				byte_idx <= byte_idx + 4'd1;
			end
			if (bus.cyc && bus.ack) begin
				bus.cyc <= 1'b0;
				bus.stb <= 1'b0;
				bus.we  <= 1'b0;
			end else if (wr_start) begin
				bus.cyc <= 1'b1;
				bus.stb <= 1'b1;
				bus.we  <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_start) begin
			bus.adr   <= wr_adr;
			bus.dat_w <= byte_i;
		end
		if (kbd_byte) begin
			if (byte_i == KBD_EXT) begin
				extended_q <= 1'b1;
				pressed_q  <= ev_pressed;
			end else if (byte_i == KBD_BREAK) begin
				pressed_q  <= 1'b0;
				extended_q <= ev_extended;
			end else begin
				key_code_o     <= byte_i;
				key_pressed_o  <= ev_pressed;
				key_extended_o <= ev_extended;
				// flags carry on to the next code of the transfer
				pressed_q      <= ev_pressed;
				extended_q     <= ev_extended;
			end
		end
	end

endmodule

`default_nettype wire

// File: byte_sync.sv
// Moves received bytes from the SPI_CLK domain into clk_sys.
// Relies on rx_byte_i and rx_first_i staying stable for one
// byte time after rx_toggle_i flips; new_byte_o lags 2 to 3 cycles.
`timescale 1ns/1ns
`default_nettype none

module byte_sync
	import user_io_types_pkg::*;
(
	input  logic  clk_sys,
	input  logic  SPI_SS_IO,
	input  byte_t rx_byte_i,
	input  logic  rx_toggle_i,
	input  logic  rx_first_i,
	output byte_t byte_o,
	output logic  new_byte_o,
	output logic  first_o
);
	logic [1:0] tog_sync;
	logic       tog_d;
	logic       toggled;

	assign toggled = tog_sync[1] ^ tog_d;

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tog_sync   <= '0;
			tog_d      <= 1'b0;
			new_byte_o <= 1'b0;
		end else begin
			tog_sync   <= {tog_sync[0], rx_toggle_i};
			tog_d      <= tog_sync[1];
			new_byte_o <= toggled;
		end
	end

	// data crossed long before the toggle got through the synchronizer
	always_ff @(posedge clk_sys) begin
		if (toggled) begin
			byte_o  <= rx_byte_i;
			first_o <= rx_first_i;
		end
	end

endmodule

`default_nettype wire

// File: spi_slave.sv
// SPI slave in the SPI_CLK domain, mode 0, MSB first.
// SPI_CLK must idle low. SPI_SS_IO high resets all counters
// and floats MISO. leds_i is sampled at the end of each byte,
// so it must be steady during a transfer.
`timescale 1ns/1ns
`default_nettype none

module spi_slave
	import user_io_types_pkg::*, user_io_cmd_pkg::*;
(
	input  logic  clk_spi_i,
	input  logic  SPI_SS_IO,
	input  logic  mosi_i,
	output logic  miso_o,
	input  byte_t leds_i,
	output byte_t rx_byte_o,
	output logic  rx_toggle_o,
	output logic  rx_first_o
);
	logic [2:0] bit_cnt;
	// saturating byte count, only "past the first byte" matters
	logic       byte_nz;
	logic [6:0] sbuf;
	byte_t      rx_now;
	byte_t      cmd;
	byte_t      tx_byte;
	logic       miso_q;

	// last bit of a byte comes straight from the pin
	assign rx_now = {sbuf, mosi_i};

	always_ff @(posedge clk_spi_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt     <= '0;
			byte_nz     <= 1'b0;
			rx_toggle_o <= 1'b0;
			cmd         <= '0;
			tx_byte     <= CORE_TYPE;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (bit_cnt == 3'd7) begin
				byte_nz     <= 1'b1;
				rx_toggle_o <= ~rx_toggle_o;
				if (!byte_nz)
					cmd <= rx_now;
				// response for the next byte
				tx_byte <= ((byte_nz ? cmd : rx_now) == CMD_LEDS) ? leds_i : '0;
			end
		end
	end

	always_ff @(posedge clk_spi_i) begin
		if (bit_cnt != 3'd7) begin
			sbuf <= {sbuf[5:0], mosi_i};
		end else begin
			rx_byte_o  <= rx_now;
			rx_first_o <= ~byte_nz;
		end
	end

	// MSB of the core type is on the line as soon as SS falls
	always_ff @(negedge clk_spi_i or posedge SPI_SS_IO) begin
		if (SPI_SS_IO)
			miso_q <= CORE_TYPE[7];
		else
			miso_q <= tx_byte[~bit_cnt];
	end

	assign miso_o = SPI_SS_IO ? 1'bz : miso_q;

endmodule

`default_nettype wire

// File: wb_if.sv
// Wishbone classic register bus, write only, one byte per cycle.
// The slave answers one cycle after stb, for one cycle.
`timescale 1ns/1ns
`default_nettype none

interface wb_if;
	logic                       cyc;
	logic                       stb;
	logic                       we;
	user_io_types_pkg::wb_adr_t adr;
	user_io_types_pkg::byte_t   dat_w;
	logic                       ack;

	// decoder side
	modport master (output cyc, stb, we, adr, dat_w, input ack);

	// register block side
	modport slave (input cyc, stb, we, adr, dat_w, output ack);
endinterface

`default_nettype wire

// File: user_io_cmd_pkg.sv
// SPI command codes, register bus map and the core type byte.
// Register addresses are byte addresses; multi-byte registers
// take base plus byte index.
`default_nettype none

package user_io_cmd_pkg;
	import user_io_types_pkg::*;

	localparam byte_t CMD_BUT_SW = 8'h01;
	localparam byte_t CMD_KBD    = 8'h05;
	localparam byte_t CMD_STATUS = 8'h1e;
	localparam byte_t CMD_LEDS   = 8'h1f;
	localparam byte_t CMD_JOY0   = 8'h60;
	localparam byte_t CMD_JOY1   = 8'h61;

	// answered on MISO during the first byte of every transfer
	localparam byte_t CORE_TYPE = 8'ha4;

	// PS/2 prefix codes
	localparam byte_t KBD_EXT   = 8'he0;
	localparam byte_t KBD_BREAK = 8'hf0;

	localparam wb_adr_t ADR_BUT_SW = 5'd0;
	localparam wb_adr_t ADR_JOY0   = 5'd4;
	localparam wb_adr_t ADR_JOY1   = 5'd8;
	localparam wb_adr_t ADR_STATUS = 5'd16;

endpackage

`default_nettype wire

// File: user_io_types_pkg.sv
// Data types and widths shared by the RTL and the testbench.
// Joystick and status words are filled least significant byte first.
`default_nettype none

package user_io_types_pkg;

	// one SPI or register bus data byte
	typedef logic [7:0] byte_t;

	// digital joystick word, byte 0 in bits 7:0
	typedef logic [31:0] joystick_t;

	// core status word as sent by the I/O controller
	typedef logic [63:0] status_t;

	// buttons, switches and video mode bits
	typedef logic [7:0] but_sw_t;

	// internal register bus address
	typedef logic [4:0] wb_adr_t;

	localparam int JOY_BYTES    = 4;
	localparam int STATUS_BYTES = 8;

endpackage

`default_nettype wire
